/* src/raster_pkg.sv */
package raster_pkg;

    // Signed 24.8 fixed point
    localparam int FRAC_BITS = 8;
    localparam int ONE       = 256;

    typedef logic signed [31:0] fix_t;

    // Products, dot terms and slope numerators
    typedef logic signed [63:0] wide_t;

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } vertex_t;

    // Current position of one edge on the active row
    typedef struct packed {
        fix_t x;
        fix_t z;
    } edge_pos_t;

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } pixel_t;

    typedef enum logic [3:0] {
        IDLE,
        SETUP,
        CULL,
        EDGE_INIT,
        ROW_START,
        ROW_RUN,
        FINISH
    } ctrl_state_t;

    typedef enum logic {
        CALC,
        SHOW
    } span_state_t;

    // Round up to the next whole pixel
    function automatic fix_t fix_ceil(fix_t v);
        fix_t frac_mask;
        frac_mask = fix_t'((1 << FRAC_BITS) - 1);
        return (v + frac_mask) & ~frac_mask;
    endfunction

endpackage

/* src/tri_setup.sv */
`timescale 1ns/1ps

module tri_setup import raster_pkg::*; (
    input  logic    CLK,
    input  logic    RESET,
    input  logic    load,
    input  vertex_t v1,
    input  vertex_t v2,
    input  vertex_t v3,
    output vertex_t bot_v,
    output vertex_t mid_v,
    output vertex_t top_v,
    output logic    culled
);

    vertex_t s_bot;
    vertex_t s_mid;
    vertex_t s_top;

    // Edge vectors from v1
    wide_t e1_x;
    wide_t e1_y;
    wide_t e1_z;
    wide_t e2_x;
    wide_t e2_y;
    wide_t e2_z;

    wide_t n_x;
    wide_t n_y;
    wide_t n_z;
    wide_t facing;

    // Bubble sort on y that swaps only on strictly greater
    // Ties keep input order
    always_comb begin
        s_bot = v1;
        s_mid = v2;
        s_top = v3;
        if (s_bot.y > s_mid.y) begin
            {s_bot, s_mid} = {s_mid, s_bot};
        end
        if (s_mid.y > s_top.y) begin
            {s_mid, s_top} = {s_top, s_mid};
        end
        if (s_bot.y > s_mid.y) begin
            {s_bot, s_mid} = {s_mid, s_bot};
        end
    end

    assign e1_x = wide_t'(v2.x) - wide_t'(v1.x);
    assign e1_y = wide_t'(v2.y) - wide_t'(v1.y);
    assign e1_z = wide_t'(v2.z) - wide_t'(v1.z);
    assign e2_x = wide_t'(v3.x) - wide_t'(v1.x);
    assign e2_y = wide_t'(v3.y) - wide_t'(v1.y);
    assign e2_z = wide_t'(v3.z) - wide_t'(v1.z);

    // Face normal
    assign n_x = e1_y * e2_z - e1_z * e2_y;
    assign n_y = e1_z * e2_x - e1_x * e2_z;
    assign n_z = e1_x * e2_y - e1_y * e2_x;

    // Facing away from the viewer when v1 and the normal agree
    assign facing = wide_t'(v1.x) * n_x + wide_t'(v1.y) * n_y + wide_t'(v1.z) * n_z;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            culled <= 1'b0;
        end else if (load) begin
            culled <= (facing >= 0);
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            bot_v <= s_bot;
            mid_v <= s_mid;
            top_v <= s_top;
        end
    end

endmodule

/* src/edge_walker.sv */
`timescale 1ns/1ps

module edge_walker import raster_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      edge_init,
    input  logic      edge_step,
    input  vertex_t   from_v,
    input  vertex_t   to_v,
    output edge_pos_t pos,
    output fix_t      row_first,
    output fix_t      row_last
);

    wide_t dx;
    wide_t dy;
    wide_t dz;
    fix_t  x_slope_in;
    fix_t  z_slope_in;

    // Per-row increments
    fix_t  x_slope;
    fix_t  z_slope;

    wide_t prestep;
    fix_t  x_start;
    fix_t  z_start;
    logic  prestep_pend;

    assign row_first = fix_ceil(from_v.y);
    assign row_last  = fix_ceil(to_v.y);

    assign dx = wide_t'(to_v.x) - wide_t'(from_v.x);
    assign dy = wide_t'(to_v.y) - wide_t'(from_v.y);
    assign dz = wide_t'(to_v.z) - wide_t'(from_v.z);

    // Flat edge has no slope
    always_comb begin
        if (dy == 0) begin
            x_slope_in = '0;
            z_slope_in = '0;
        end else begin
            x_slope_in = fix_t'((dx * ONE) / dy);
            z_slope_in = fix_t'((dz * ONE) / dy);
        end
    end

    // Move from the vertex down to the first pixel row center
    assign prestep = wide_t'(row_first) - wide_t'(from_v.y);
    assign x_start = fix_t'(wide_t'(from_v.x) + (prestep * x_slope) / ONE);
    assign z_start = fix_t'(wide_t'(from_v.z) + (prestep * z_slope) / ONE);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            prestep_pend <= 1'b0;
        end else begin
            prestep_pend <= edge_init;
        end
    end

    always_ff @(posedge CLK) begin
        if (edge_init) begin
            x_slope <= x_slope_in;
            z_slope <= z_slope_in;
        end
        if (prestep_pend) begin
            pos.x <= x_start;
            pos.z <= z_start;
        end else if (edge_step) begin
            pos.x <= pos.x + x_slope;
            pos.z <= pos.z + z_slope;
        end
    end

endmodule

/* src/span_walker.sv */
`timescale 1ns/1ps

module span_walker import raster_pkg::*; #(
    parameter int SCREEN_W = 640
) (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      span_init,
    input  edge_pos_t left,
    input  edge_pos_t right,
    input  fix_t      row_y,
    input  logic      cont,
    output pixel_t    pixel,
    output logic      pixel_valid,
    output logic      span_done
);

    // Right clip edge in fixed point
    localparam fix_t CLIP_X = fix_t'(SCREEN_W * ONE);

    span_state_t state;
    logic        active;

    fix_t  x_first;
    fix_t  x_last;
    wide_t dz_num;
    wide_t dx_len;
    fix_t  dz_in;

    fix_t  x_cnt;
    fix_t  x_end;
    fix_t  z_cnt;
    fix_t  dz;
    fix_t  y_reg;
    logic  last_pix;

    assign x_first = fix_ceil(left.x);
    assign x_last  = fix_ceil(right.x);

    // z slope is worked out in the span_init cycle itself
    assign dz_num = (wide_t'(right.z) - wide_t'(left.z)) * ONE;
    assign dx_len = wide_t'(x_last) - wide_t'(x_first);
    assign dz_in  = (dx_len == 0) ? '0 : fix_t'(dz_num / dx_len);

    assign pixel_valid = active && (state == SHOW);

    // End point is drawn too
    assign last_pix = (x_cnt >= x_end) || (x_cnt >= CLIP_X);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active    <= 1'b0;
            state     <= CALC;
            span_done <= 1'b0;
        end else begin
            span_done <= 1'b0;
            if (span_init) begin
                active <= 1'b1;
                state  <= CALC;
            end else if (active) begin
                case (state)
                    CALC: state <= SHOW;
                    SHOW: begin
                        if (cont) begin
                            state <= CALC;
                            if (last_pix) begin
                                active    <= 1'b0;
                                span_done <= 1'b1;
                            end
                        end
                    end
                    default: state <= CALC;
                endcase
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (span_init) begin
            x_cnt <= x_first;
            x_end <= x_last;
            z_cnt <= left.z;
            dz    <= dz_in;
            y_reg <= row_y;
        end else if (pixel_valid && cont) begin
            x_cnt <= x_cnt + fix_t'(ONE);
            z_cnt <= z_cnt + dz;
        end
        // Output register only changes in CALC, so it holds under back-pressure
        if (active && (state == CALC)) begin
            pixel <= '{x: x_cnt, y: y_reg, z: z_cnt};
        end
    end

endmodule

/* src/raster_ctrl.sv */
`timescale 1ns/1ps

module raster_ctrl import raster_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      start,
    input  logic      culled,
    input  fix_t      low_first,
    input  fix_t      low_last,
    input  fix_t      high_first,
    input  fix_t      high_last,
    input  edge_pos_t long_pos,
    input  edge_pos_t low_pos,
    input  edge_pos_t high_pos,
    input  logic      span_done,
    output logic      load,
    output logic      edge_init,
    output logic      step_long,
    output logic      step_low,
    output logic      step_high,
    output logic      span_init,
    output edge_pos_t left,
    output edge_pos_t right,
    output fix_t      row_y,
    output logic      done
);

    ctrl_state_t state;

    // Low for bot to mid and high for mid to top
    logic        top_half;
    logic [1:0]  wait_cnt;
    fix_t        y_cnt;

    edge_pos_t   short_pos;
    fix_t        half_last;
    logic        row_in_half;
    logic        short_left;

    assign short_pos   = top_half ? high_pos : low_pos;
    assign half_last   = top_half ? high_last : low_last;
    assign row_in_half = (y_cnt < half_last);

    // Span sides from the ceiled edge x values
    assign short_left = (fix_ceil(short_pos.x) < fix_ceil(long_pos.x));
    assign left       = short_left ? short_pos : long_pos;
    assign right      = short_left ? long_pos : short_pos;
    assign row_y      = y_cnt;

    assign load      = (state == SETUP);
    assign edge_init = (state == EDGE_INIT) && (wait_cnt == 2'd0);
    assign span_init = (state == ROW_START) && row_in_half;
    assign done      = (state == FINISH);

    // Long edge steps every row along with the short edge of the current half
    assign step_long = (state == ROW_RUN) && span_done;
    assign step_low  = step_long && !top_half;
    assign step_high = step_long && top_half;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= IDLE;
            top_half <= 1'b0;
            wait_cnt <= 2'd0;
            y_cnt    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    wait_cnt <= 2'd0;
                    if (start) begin
                        state <= SETUP;
                    end
                end
                SETUP: state <= CULL;
                CULL: begin
                    wait_cnt <= 2'd0;
                    if (culled) begin
                        state <= FINISH;
                    end else begin
                        state <= EDGE_INIT;
                    end
                end
                EDGE_INIT: begin
                    // Two cycles for slope and prestep in the walkers
                    wait_cnt <= wait_cnt + 2'd1;
                    if (wait_cnt == 2'd2) begin
                        y_cnt    <= low_first;
                        top_half <= 1'b0;
                        state    <= ROW_START;
                    end
                end
                ROW_START: begin
                    if (row_in_half) begin
                        state <= ROW_RUN;
                    end else if (!top_half) begin
                        top_half <= 1'b1;
                        y_cnt    <= high_first;
                    end else begin
                        state <= FINISH;
                    end
                end
                ROW_RUN: begin
                    if (span_done) begin
                        y_cnt <= y_cnt + fix_t'(ONE);
                        state <= ROW_START;
                    end
                end
                FINISH: begin
                    if (!start) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* src/raster_top.sv */
`timescale 1ns/1ps

module raster_top import raster_pkg::*; #(
    parameter int SCREEN_W = 640
) (
    input  logic    CLK,
    input  logic    RESET,
    input  logic    start,
    input  logic    cont,
    input  vertex_t v1,
    input  vertex_t v2,
    input  vertex_t v3,
    output pixel_t  pixel,
    output logic    pixel_valid,
    output logic    done
);

    logic      load;
    logic      culled;
    vertex_t   bot_v;
    vertex_t   mid_v;
    vertex_t   top_v;

    logic      edge_init;
    logic      step_long;
    logic      step_low;
    logic      step_high;
    edge_pos_t long_pos;
    edge_pos_t low_pos;
    edge_pos_t high_pos;
    fix_t      low_first;
    fix_t      low_last;
    fix_t      high_first;
    fix_t      high_last;

    logic      span_init;
    logic      span_done;
    edge_pos_t left;
    edge_pos_t right;
    fix_t      row_y;

    raster_ctrl u_ctrl (
        .CLK        (CLK),
        .RESET      (RESET),
        .start      (start),
        .culled     (culled),
        .low_first  (low_first),
        .low_last   (low_last),
        .high_first (high_first),
        .high_last  (high_last),
        .long_pos   (long_pos),
        .low_pos    (low_pos),
        .high_pos   (high_pos),
        .span_done  (span_done),
        .load       (load),
        .edge_init  (edge_init),
        .step_long  (step_long),
        .step_low   (step_low),
        .step_high  (step_high),
        .span_init  (span_init),
        .left       (left),
        .right      (right),
        .row_y      (row_y),
        .done       (done)
    );

    tri_setup u_setup (
        .CLK    (CLK),
        .RESET  (RESET),
        .load   (load),
        .v1     (v1),
        .v2     (v2),
        .v3     (v3),
        .bot_v  (bot_v),
        .mid_v  (mid_v),
        .top_v  (top_v),
        .culled (culled)
    );

    // Row bounds come from the short edges only
    edge_walker e_long (
        .CLK       (CLK),
        .RESET     (RESET),
        .edge_init (edge_init),
        .edge_step (step_long),
        .from_v    (bot_v),
        .to_v      (top_v),
        .pos       (long_pos),
        .row_first (),
        .row_last  ()
    );

    edge_walker e_low (
        .CLK       (CLK),
        .RESET     (RESET),
        .edge_init (edge_init),
        .edge_step (step_low),
        .from_v    (bot_v),
        .to_v      (mid_v),
        .pos       (low_pos),
        .row_first (low_first),
        .row_last  (low_last)
    );

    edge_walker e_high (
        .CLK       (CLK),
        .RESET     (RESET),
        .edge_init (edge_init),
        .edge_step (step_high),
        .from_v    (mid_v),
        .to_v      (top_v),
        .pos       (high_pos),
        .row_first (high_first),
        .row_last  (high_last)
    );

    span_walker #(
        .SCREEN_W (SCREEN_W)
    ) u_span (
        .CLK         (CLK),
        .RESET       (RESET),
        .span_init   (span_init),
        .left        (left),
        .right       (right),
        .row_y       (row_y),
        .cont        (cont),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .span_done   (span_done)
    );

endmodule

/* dv/raster_props.sv */
`timescale 1ns/1ps

module raster_props import raster_pkg::*; (
    input logic   CLK,
    input logic   RESET,
    input logic   span_init,
    input logic   cont,
    input logic   pixel_valid,
    input logic   done,
    input pixel_t pixel
);

    // Failure count for the closing summary
    int fail_cnt = 0;

    // Triangle end and a presented pixel never overlap
    a_done_no_pixel: assert property (@(posedge CLK) disable iff (RESET)
        !(done && pixel_valid))
        else begin
            fail_cnt++;
            $error("done is high while a pixel is presented");
        end

    // A new span only starts once the last pixel is gone
    a_init_idle: assert property (@(posedge CLK) disable iff (RESET)
        span_init |-> !pixel_valid)
        else begin
            fail_cnt++;
            $error("span_init issued while a pixel is still presented");
        end

    // Held pixel stays put until the consumer takes it
    a_hold: assert property (@(posedge CLK) disable iff (RESET)
        (pixel_valid && !cont) |=> (pixel_valid && $stable(pixel)))
        else begin
            fail_cnt++;
            $error("pixel changed or dropped while cont was low");
        end

endmodule

/* dv/raster_tb.sv */
`timescale 1ns/1ps

module raster_tb import raster_pkg::*; ();

    localparam int      SCREEN_W = 24;
    localparam fix_t    CLIP_X   = fix_t'(SCREEN_W * ONE);
    localparam int      N_RANDOM = 12;

    // Front-facing triangle with a different z per vertex
    localparam vertex_t FRONT_A = '{x: 2688, y: 576, z: 2048};
    localparam vertex_t FRONT_B = '{x: 960, y: 2944, z: 3072};
    localparam vertex_t FRONT_C = '{x: 4672, y: 3584, z: 4096};

    // Reaches past the right screen edge
    localparam vertex_t CLIP_A = '{x: 3584, y: 384, z: 10240};
    localparam vertex_t CLIP_B = '{x: 2560, y: 2304, z: 5120};
    localparam vertex_t CLIP_C = '{x: 8064, y: 3136, z: 15360};

    logic        CLK = 1'b0;
    logic        RESET;
    logic        start;
    logic        cont;
    vertex_t     v1;
    vertex_t     v2;
    vertex_t     v3;
    pixel_t      pixel;
    logic        pixel_valid;
    logic        done;

    pixel_t      exp_q[$];
    string       test_name = "reset";
    logic [31:0] lfsr_state;
    logic        use_gaps;
    int          gap_left;
    logic        last_cull;
    int          clip_rows;
    int          pix_err = 0;
    int          extra_err = 0;
    int          other_err = 0;
    logic        watch_on = 1'b0;
    int          watch_limit = 0;
    int          watch_cnt = 0;

    raster_top #(
        .SCREEN_W (SCREEN_W)
    ) dut0 (
        .CLK         (CLK),
        .RESET       (RESET),
        .start       (start),
        .cont        (cont),
        .v1          (v1),
        .v2          (v2),
        .v3          (v3),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .done        (done)
    );

    bind raster_top raster_props props0 (
        .CLK         (CLK),
        .RESET       (RESET),
        .span_init   (span_init),
        .cont        (cont),
        .pixel_valid (pixel_valid),
        .done        (done),
        .pixel       (pixel)
    );

    always #50 CLK = ~CLK;

    // One Galois step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return r;
    endfunction

    function automatic fix_t ceil_px(input fix_t v);
        return ((v + 255) >>> FRAC_BITS) <<< FRAC_BITS;
    endfunction

    function automatic fix_t slope_of(input wide_t num, input wide_t dy);
        if (dy == 0) begin
            return '0;
        end
        return fix_t'((num * ONE) / dy);
    endfunction

    // Edge start on its first row plus per-row increments
    function automatic void edge_start(input vertex_t f, input vertex_t t,
                                       output edge_pos_t p, output edge_pos_t d);
        wide_t dy;
        wide_t pre;
        dy   = wide_t'(t.y) - wide_t'(f.y);
        d.x  = slope_of(wide_t'(t.x) - wide_t'(f.x), dy);
        d.z  = slope_of(wide_t'(t.z) - wide_t'(f.z), dy);
        pre  = wide_t'(ceil_px(f.y)) - wide_t'(f.y);
        p.x  = fix_t'(wide_t'(f.x) + (pre * wide_t'(d.x)) / ONE);
        p.z  = fix_t'(wide_t'(f.z) + (pre * wide_t'(d.z)) / ONE);
    endfunction

    function automatic edge_pos_t step_edge(input edge_pos_t p, input edge_pos_t d);
        return '{x: p.x + d.x, z: p.z + d.z};
    endfunction

    function automatic void emit_span(input edge_pos_t l, input edge_pos_t r, input fix_t y);
        fix_t  px;
        fix_t  pz;
        fix_t  xe;
        fix_t  dz;
        wide_t len;
        logic  last;
        px   = ceil_px(l.x);
        xe   = ceil_px(r.x);
        pz   = l.z;
        len  = wide_t'(xe) - wide_t'(px);
        dz   = (len == 0) ? '0 : fix_t'(((wide_t'(r.z) - wide_t'(l.z)) * ONE) / len);
        last = 1'b0;
        while (!last) begin
            exp_q.push_back('{x: px, y: y, z: pz});
            last = (px >= xe) || (px >= CLIP_X);
            if (last && (px < xe)) begin
                clip_rows++;
            end
            px = px + fix_t'(ONE);
            pz = pz + dz;
        end
    endfunction

    function automatic void draw_row(input edge_pos_t lg, input edge_pos_t sh, input fix_t y);
        if (ceil_px(sh.x) < ceil_px(lg.x)) begin
            emit_span(sh, lg, y);
        end else begin
            emit_span(lg, sh, y);
        end
    endfunction

    // Fills exp_q with the expected pixels and returns the cull flag
    function automatic logic ref_raster(input vertex_t a, input vertex_t b, input vertex_t c);
        wide_t     e1_x, e1_y, e1_z;
        wide_t     e2_x, e2_y, e2_z;
        wide_t     n_x, n_y, n_z;
        vertex_t   s0, s1, s2;
        edge_pos_t lg, lg_d, sh, sh_d;
        fix_t      y;
        exp_q.delete();
        clip_rows = 0;
        e1_x = wide_t'(b.x) - wide_t'(a.x);
        e1_y = wide_t'(b.y) - wide_t'(a.y);
        e1_z = wide_t'(b.z) - wide_t'(a.z);
        e2_x = wide_t'(c.x) - wide_t'(a.x);
        e2_y = wide_t'(c.y) - wide_t'(a.y);
        e2_z = wide_t'(c.z) - wide_t'(a.z);
        n_x  = e1_y * e2_z - e1_z * e2_y;
        n_y  = e1_z * e2_x - e1_x * e2_z;
        n_z  = e1_x * e2_y - e1_y * e2_x;
        if (wide_t'(a.x) * n_x + wide_t'(a.y) * n_y + wide_t'(a.z) * n_z >= 0) begin
            return 1'b1;
        end
        // Ascending y with ties kept in input order
        s0 = a;
        s1 = b;
        s2 = c;
        if (s0.y > s1.y) begin
            {s0, s1} = {s1, s0};
        end
        if (s1.y > s2.y) begin
            {s1, s2} = {s2, s1};
        end
        if (s0.y > s1.y) begin
            {s0, s1} = {s1, s0};
        end
        edge_start(s0, s2, lg, lg_d);
        edge_start(s0, s1, sh, sh_d);
        for (y = ceil_px(s0.y); y < ceil_px(s1.y); y = y + fix_t'(ONE)) begin
            draw_row(lg, sh, y);
            lg = step_edge(lg, lg_d);
            sh = step_edge(sh, sh_d);
        end
        edge_start(s1, s2, sh, sh_d);
        for (y = ceil_px(s1.y); y < ceil_px(s2.y); y = y + fix_t'(ONE)) begin
            draw_row(lg, sh, y);
            lg = step_edge(lg, lg_d);
            sh = step_edge(sh, sh_d);
        end
        return 1'b0;
    endfunction

    function automatic vertex_t rand_vertex();
        vertex_t v;
        v.x = fix_t'(take_bits(13));
        v.y = fix_t'(take_bits(12));
        v.z = fix_t'(take_bits(14));
        return v;
    endfunction

    task automatic finish_run(input logic hung);
        int prop_err;
        prop_err = dut0.props0.fail_cnt;
        $display("errors: pixel=%0d extra=%0d other=%0d prop=%0d timeout=%0d",
                 pix_err, extra_err, other_err, prop_err, hung);
        if (!hung && pix_err == 0 && extra_err == 0 && other_err == 0 && prop_err == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // Consumer side with random gaps and stray cont pulses when enabled
    task automatic drive_cont();
        logic [31:0] r;
        if (!pixel_valid) begin
            cont = 1'b0;
            if (use_gaps) begin
                r    = take_bits(1);
                cont = r[0];
            end
        end else if (gap_left > 0) begin
            cont = 1'b0;
            gap_left--;
        end else begin
            cont = 1'b1;
            if (use_gaps) begin
                r        = take_bits(2);
                gap_left = int'(r);
            end
        end
    endtask

    task automatic check_idle(input int cycles);
        test_name = "idle";
        repeat (cycles) begin
            @(posedge CLK);
            assert (!pixel_valid && !done) else begin
                other_err++;
                $display("pixel_valid or done went high while start was low");
            end
        end
    endtask

    task automatic run_tri(input string name, input vertex_t a, input vertex_t b,
                           input vertex_t c);
        test_name = name;
        last_cull = ref_raster(a, b, c);
        @(negedge CLK);
        v1          = a;
        v2          = b;
        v3          = c;
        start       = 1'b1;
        watch_limit = exp_q.size() * 8 + 40;
        watch_on    = 1'b1;
        while (!done) begin
            @(negedge CLK);
            drive_cont();
        end
        cont = 1'b0;
        assert (exp_q.size() == 0) else begin
            other_err++;
            $display("test %s finished with %0d pixels never delivered", name, exp_q.size());
        end
        start = 1'b0;
        while (done) begin
            @(negedge CLK);
        end
        watch_on = 1'b0;
    endtask

    // Every consumed pixel is checked against the reference queue
    always @(posedge CLK) begin
        pixel_t exp_pix;
        if (!RESET && pixel_valid && cont) begin
            assert (exp_q.size() > 0) else begin
                extra_err++;
                $display("test %s produced an extra pixel at x=%0d y=%0d",
                         test_name, pixel.x, pixel.y);
            end
            if (exp_q.size() > 0) begin
                exp_pix = exp_q.pop_front();
                assert (pixel == exp_pix) else begin
                    pix_err++;
                    $display("ERR %s expected (%0d,%0d,%0d) actual (%0d,%0d,%0d)", test_name,
                             exp_pix.x, exp_pix.y, exp_pix.z, pixel.x, pixel.y, pixel.z);
                end
            end
        end
    end

    always @(posedge CLK) begin
        if (!watch_on) begin
            watch_cnt <= 0;
        end else if (watch_cnt >= watch_limit) begin
            $display("timeout: test %s saw no done within %0d cycles", test_name, watch_limit);
            finish_run(1'b1);
        end else begin
            watch_cnt <= watch_cnt + 1;
        end
    end

    initial begin
        vertex_t ra;
        vertex_t rb;
        vertex_t rc;
        RESET      = 1'b1;
        start      = 1'b0;
        cont       = 1'b0;
        v1         = '0;
        v2         = '0;
        v3         = '0;
        use_gaps   = 1'b0;
        gap_left   = 0;
        lfsr_state = 32'h960f;
        repeat (10) @(negedge CLK);
        RESET = 1'b0;

        check_idle(20);

        run_tri("front", FRONT_A, FRONT_B, FRONT_C);
        assert (!last_cull) else begin
            other_err++;
            $display("front triangle was not front-facing in the reference");
        end

        run_tri("back", FRONT_C, FRONT_B, FRONT_A);
        assert (last_cull) else begin
            other_err++;
            $display("reversed triangle was not culled in the reference");
        end

        use_gaps = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            ra = rand_vertex();
            rb = rand_vertex();
            rc = rand_vertex();
            run_tri($sformatf("random%0d", i), ra, rb, rc);
        end
        use_gaps = 1'b0;
        gap_left = 0;

        run_tri("clip", CLIP_A, CLIP_B, CLIP_C);
        assert (!last_cull && clip_rows > 0) else begin
            other_err++;
            $display("clip triangle did not reach the screen edge in the reference");
        end

        // Back from idle with a second triangle
        run_tri("again", FRONT_A, FRONT_B, FRONT_C);

        finish_run(1'b0);
    end

endmodule

/* vlog.f */
src/raster_pkg.sv
src/tri_setup.sv
src/edge_walker.sv
src/span_walker.sv
src/raster_ctrl.sv
src/raster_top.sv
dv/raster_props.sv
dv/raster_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the rasterizer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f vlog.f --top-module raster_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vraster_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The pass line decides the result
if echo "$output" | grep -qx ">>> PASS"; then
    exit 0
else
    exit 1
fi
